//--- common/ciPkg.sv
package ciPkg;

  // custom instruction numbers as seen on ciN
  localparam logic [7:0] CiSwapByte = 8'd1;
  localparam logic [7:0] CiDelay    = 8'd6;
  localparam logic [7:0] CiGray     = 8'd9;
  localparam logic [7:0] CiProfile  = 8'd12;

  // profiler control bits, carried in operand B
  localparam int ProfClear   = 0; // zero all counters
  localparam int ProfEnable  = 1; // start counting
  localparam int ProfDisable = 2; // stop counting, wins over enable

  // profiler counter select, carried in operand A bits 1:0
  localparam logic [1:0] SelCycles = 2'd0;
  localparam logic [1:0] SelStall  = 2'd1;
  localparam logic [1:0] SelIdle   = 2'd2;

  // system clock runs at 74.25 MHz, the fraction is dropped
  localparam int SysClockPerMicro = 74;

endpackage

//--- common/dataPkg.sv
package dataPkg;

  localparam int CiWordWidth = 32; // operand and result words

  // RGB565 pixel layout
  localparam int RedWidth   = 5;
  localparam int GreenWidth = 6;
  localparam int BlueWidth  = 5;

  // luminance weights, scaled so that they add up to 256
  localparam int GrayRedWeight   = 54;
  localparam int GrayGreenWeight = 183;
  localparam int GrayBlueWeight  = 19;

  // operand A is read as bytes by the byte swap and as a pixel by the grayscale unit
  typedef union packed {
    logic [CiWordWidth/8-1:0][7:0] bytes; // bytes[0] is least significant
    struct packed {
      logic [CiWordWidth-RedWidth-GreenWidth-BlueWidth-1:0] pad;
      logic [RedWidth-1:0]   red;
      logic [GreenWidth-1:0] green;
      logic [BlueWidth-1:0]  blue;
    } pixel;
  } ciWordT;

endpackage

//--- logic/ciDecode.sv
`timescale 1ns/1ps

module ciDecode
  import ciPkg::*;
(
  input  logic       ciStart,
  input  logic [7:0] ciN,
  output logic       swapStart,
  output logic       grayStart,
  output logic       profileStart,
  output logic       delayStart,
  output logic       illegalDone
);

  logic isSwap;
  logic isGray;
  logic isProfile;
  logic isDelay;

  assign isSwap    = (ciN == CiSwapByte);
  assign isGray    = (ciN == CiGray);
  assign isProfile = (ciN == CiProfile);
  assign isDelay   = (ciN == CiDelay);

  assign swapStart    = ciStart & isSwap;
  assign grayStart    = ciStart & isGray;
  assign profileStart = ciStart & isProfile;
  assign delayStart   = ciStart & isDelay;

  // unknown number finishes at once so the processor does not hang
  assign illegalDone = ciStart & ~(isSwap | isGray | isProfile | isDelay);

  // exactly one path answers a start, the illegal one included
  always_comb begin
    assert final ($onehot0({swapStart, grayStart, profileStart, delayStart, illegalDone}))
      else $error("ciDecode: more than one unit started");
  end

endmodule

//--- execute/pixelOps.sv
`timescale 1ns/1ps

module pixelOps
  import dataPkg::*;
(
  input  logic                   swapStart,
  input  logic                   grayStart,
  input  ciWordT                 ciDataA,
  input  logic [CiWordWidth-1:0] ciDataB,
  output logic                   swapDone,
  output logic [CiWordWidth-1:0] swapResult,
  output logic                   grayDone,
  output logic [CiWordWidth-1:0] grayResult
);

  logic [CiWordWidth-1:0] swapped;
  logic [7:0]             red8;
  logic [7:0]             green8;
  logic [7:0]             blue8;
  logic [CiWordWidth-1:0] graySum;

  // B bit 0 picks half-word swap instead of the full reverse
  always_comb begin
    if (ciDataB[0]) begin
      swapped = {ciDataA.bytes[2], ciDataA.bytes[3], ciDataA.bytes[0], ciDataA.bytes[1]};
    end else begin
      swapped = {ciDataA.bytes[0], ciDataA.bytes[1], ciDataA.bytes[2], ciDataA.bytes[3]};
    end
  end

  // widen each field to 8 bits, low bits filled with zeros
  assign red8   = {ciDataA.pixel.red, {(8 - RedWidth){1'b0}}};
  assign green8 = {ciDataA.pixel.green, {(8 - GreenWidth){1'b0}}};
  assign blue8  = {ciDataA.pixel.blue, {(8 - BlueWidth){1'b0}}};

  // weights add up to 256, so the sum stays below 2^16
  assign graySum = GrayRedWeight * red8 + GrayGreenWeight * green8 + GrayBlueWeight * blue8;

  assign swapDone   = swapStart;
  assign swapResult = swapStart ? swapped : '0;
  assign grayDone   = grayStart;
  assign grayResult = grayStart ? {8'd0, graySum[CiWordWidth-1:8]} : '0;

endmodule

//--- execute/profileCounters.sv
`timescale 1ns/1ps

module profileCounters
  import ciPkg::*, dataPkg::*;
(
  input  logic                   systemClock,
  input  logic                   rstN,
  input  logic                   profileStart,
  input  logic                   stall,
  input  logic                   busIdle,
  input  logic [CiWordWidth-1:0] ciDataA,
  input  logic [CiWordWidth-1:0] ciDataB,
  output logic                   profileDone,
  output logic [CiWordWidth-1:0] profileResult
);

  logic                   enabled;
  logic                   doClear;
  logic                   doEnable;
  logic                   doDisable;
  logic [2:0]             tick;
  logic [CiWordWidth-1:0] counts [3]; // indexed by select code
  logic [CiWordWidth-1:0] selected;

  assign doClear   = profileStart & ciDataB[ProfClear];
  assign doEnable  = profileStart & ciDataB[ProfEnable];
  assign doDisable = profileStart & ciDataB[ProfDisable];

  assign tick[SelCycles] = 1'b1;
  assign tick[SelStall]  = stall;
  assign tick[SelIdle]   = busIdle;

  always_ff @(posedge systemClock) begin
    if (!rstN) begin
      enabled <= 1'b0;
      for (int i = 0; i < 3; i++) counts[i] <= '0;
    end else begin
      // counting on this edge still uses the old enable
      for (int i = 0; i < 3; i++) begin
        if (doClear) counts[i] <= '0;
        else if (enabled && tick[i]) counts[i] <= counts[i] + 1'b1; // wraps
      end
      if (doDisable) enabled <= 1'b0;
      else if (doEnable) enabled <= 1'b1;
    end
  end

  always_comb begin
    case (ciDataA[1:0])
      SelCycles: selected = counts[SelCycles];
      SelStall:  selected = counts[SelStall];
      SelIdle:   selected = counts[SelIdle];
      default:   selected = '0;
    endcase
  end

  // value from before the edge that applies the control bits
  assign profileDone   = profileStart;
  assign profileResult = profileStart ? selected : '0;

endmodule

//--- execute/delayTimer.sv
`timescale 1ns/1ps

module delayTimer
  import ciPkg::*;
(
  input  logic        systemClock,
  input  logic        rstN,
  input  logic        delayStart,
  input  logic [31:0] ciDataA,
  output logic        delayDone
);

  logic [39:0] remaining; // room for a full 32-bit microsecond count
  logic        busy;
  logic        zeroDelay;

  assign busy      = (remaining != '0);
  assign zeroDelay = delayStart & (ciDataA == '0);

  // cycle 1 holds the full count and done comes with one cycle left
  always_ff @(posedge systemClock) begin
    if (!rstN) begin
      remaining <= '0;
    end else if (delayStart) begin
      remaining <= ciDataA * SysClockPerMicro;
    end else if (busy) begin
      remaining <= remaining - 1'b1;
    end
  end

  assign delayDone = zeroDelay | (remaining == 40'd1);

  // processor waits for done before it issues the next instruction
  property noStartWhileBusy;
    @(posedge systemClock) disable iff (!rstN)
      delayStart |-> !busy;
  endproperty

  assert property (noStartWhileBusy)
    else $error("delayTimer: start while a delay is running");

endmodule

//--- logic/ciResult.sv
`timescale 1ns/1ps

module ciResult
  import dataPkg::*;
(
  input  logic                   swapDone,
  input  logic                   grayDone,
  input  logic                   profileDone,
  input  logic                   delayDone,
  input  logic                   illegalDone,
  input  logic [CiWordWidth-1:0] swapResult,
  input  logic [CiWordWidth-1:0] grayResult,
  input  logic [CiWordWidth-1:0] profileResult,
  output logic                   ciDone,
  output logic [CiWordWidth-1:0] ciResult
);

  // delay and illegal paths always return zero
  assign ciDone   = swapDone | grayDone | profileDone | delayDone | illegalDone;
  assign ciResult = swapResult | grayResult | profileResult;

  // the OR merge only works if idle units keep their results at zero
  always_comb begin
    assert final ($onehot0({swapDone, grayDone, profileDone, delayDone, illegalDone}))
      else $error("ciResult: more than one unit done");
    assert final (swapDone || swapResult == '0)
      else $error("ciResult: swap result without done");
    assert final (grayDone || grayResult == '0)
      else $error("ciResult: gray result without done");
    assert final (profileDone || profileResult == '0)
      else $error("ciResult: profile result without done");
  end

endmodule

//--- logic/ciCluster.sv
`timescale 1ns/1ps

module ciCluster
  import dataPkg::*;
(
  input  logic                   systemClock, // 74.25MHz
  input  logic                   rstN,
  input  logic                   ciStart,
  input  logic [7:0]             ciN,
  input  logic [CiWordWidth-1:0] ciDataA,
  input  logic [CiWordWidth-1:0] ciDataB,
  input  logic                   stall,
  input  logic                   busIdle,
  output logic                   ciDone,
  output logic [CiWordWidth-1:0] ciResult
);

  logic                   swapStart, grayStart, profileStart, delayStart, illegalDone;
  logic                   swapDone, grayDone, profileDone, delayDone;
  logic [CiWordWidth-1:0] swapResult, grayResult, profileResult;

  ciDecode decode (
    .ciStart(ciStart),
    .ciN(ciN),
    .swapStart(swapStart),
    .grayStart(grayStart),
    .profileStart(profileStart),
    .delayStart(delayStart),
    .illegalDone(illegalDone)
  );

  pixelOps pixel (
    .swapStart(swapStart),
    .grayStart(grayStart),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .swapDone(swapDone),
    .swapResult(swapResult),
    .grayDone(grayDone),
    .grayResult(grayResult)
  );

  profileCounters profiler (
    .systemClock(systemClock),
    .rstN(rstN),
    .profileStart(profileStart),
    .stall(stall),
    .busIdle(busIdle),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .profileDone(profileDone),
    .profileResult(profileResult)
  );

  delayTimer delayMicro (
    .systemClock(systemClock),
    .rstN(rstN),
    .delayStart(delayStart),
    .ciDataA(ciDataA),
    .delayDone(delayDone)
  );

  ciResult merge (
    .swapDone(swapDone),
    .grayDone(grayDone),
    .profileDone(profileDone),
    .delayDone(delayDone),
    .illegalDone(illegalDone),
    .swapResult(swapResult),
    .grayResult(grayResult),
    .profileResult(profileResult),
    .ciDone(ciDone),
    .ciResult(ciResult)
  );

endmodule

//--- dv/ciVectors.svh
`ifndef ciVectorsSvh
`define ciVectorsSvh

// columns: instruction number, operand A, operand B, stall, busIdle, expected result
// profiler entries are checked against the reference model, their expected column is unused
typedef struct packed {
  logic [7:0]  n;
  logic [31:0] a;
  logic [31:0] b;
  logic        stall;
  logic        idle;
  logic [31:0] expected;
} vecT;

localparam int NumVectors    = 32;
localparam int MaxDelayMicro = 2; // longest delay in the table

vecT vectors [NumVectors];

task automatic loadVectors();
  vectors[0]  = '{CiSwapByte, 32'h12345678, 32'h0, 1'b0, 1'b0, 32'h78563412};
  vectors[1]  = '{CiSwapByte, 32'h12345678, 32'h1, 1'b0, 1'b0, 32'h34127856};
  vectors[2]  = '{CiSwapByte, 32'hdeadbeef, 32'h0, 1'b0, 1'b0, 32'hefbeadde};
  vectors[3]  = '{CiSwapByte, 32'hdeadbeef, 32'h1, 1'b0, 1'b0, 32'haddeefbe};
  vectors[4]  = '{CiSwapByte, 32'h000000ff, 32'h2, 1'b0, 1'b0, 32'hff000000};
  vectors[5]  = '{CiGray, 32'h0000ffff, 32'h0, 1'b0, 1'b0, 32'h000000fa}; // all ones
  vectors[6]  = '{CiGray, 32'h00000000, 32'h0, 1'b0, 1'b0, 32'h00000000};
  vectors[7]  = '{CiGray, 32'h0000f800, 32'h0, 1'b0, 1'b0, 32'h00000034}; // pure red
  vectors[8]  = '{CiGray, 32'h000007e0, 32'h0, 1'b0, 1'b0, 32'h000000b4}; // pure green
  vectors[9]  = '{CiGray, 32'h0000001f, 32'h0, 1'b0, 1'b0, 32'h00000012}; // pure blue
  vectors[10] = '{CiGray, 32'h12348410, 32'h0, 1'b0, 1'b0, 32'h00000080};
  vectors[11] = '{CiGray, 32'habcd0000, 32'h5, 1'b0, 1'b0, 32'h00000000}; // padding only
  vectors[12] = '{8'd200, 32'hffffffff, 32'hffffffff, 1'b0, 1'b0, 32'h0};
  vectors[13] = '{8'd0, 32'h00000001, 32'h0, 1'b0, 1'b0, 32'h0};
  vectors[14] = '{CiDelay, 32'h0, 32'h0, 1'b0, 1'b0, 32'h0};
  // profiler: clear and enable, then some traffic with stall and idle levels
  vectors[15] = '{CiProfile, 32'h0, 32'h3, 1'b0, 1'b0, 32'h0};
  vectors[16] = '{CiSwapByte, 32'h12345678, 32'h0, 1'b1, 1'b0, 32'h78563412};
  vectors[17] = '{CiGray, 32'h0000ffff, 32'h0, 1'b0, 1'b1, 32'h000000fa};
  vectors[18] = '{CiDelay, 32'h1, 32'h0, 1'b1, 1'b1, 32'h0};
  vectors[19] = '{8'd200, 32'h0, 32'h0, 1'b0, 1'b1, 32'h0};
  vectors[20] = '{CiProfile, 32'h1, 32'h0, 1'b1, 1'b0, 32'h0}; // read while counting
  vectors[21] = '{CiProfile, 32'h0, 32'h4, 1'b1, 1'b1, 32'h0}; // disable
  vectors[22] = '{CiProfile, 32'h0, 32'h0, 1'b1, 1'b1, 32'h0};
  vectors[23] = '{CiProfile, 32'h1, 32'h0, 1'b0, 1'b0, 32'h0};
  vectors[24] = '{CiProfile, 32'h2, 32'h0, 1'b0, 1'b0, 32'h0};
  vectors[25] = '{CiProfile, 32'h3, 32'h0, 1'b0, 1'b0, 32'h0}; // select 3 reads zero
  vectors[26] = '{CiDelay, 32'h2, 32'h0, 1'b1, 1'b1, 32'h0};
  vectors[27] = '{CiProfile, 32'h0, 32'h0, 1'b1, 1'b1, 32'h0};
  vectors[28] = '{CiProfile, 32'h1, 32'h0, 1'b1, 1'b1, 32'h0};
  vectors[29] = '{CiProfile, 32'h2, 32'h0, 1'b0, 1'b0, 32'h0};
  vectors[30] = '{CiProfile, 32'h0, 32'h6, 1'b1, 1'b0, 32'h0}; // disable beats enable
  vectors[31] = '{CiProfile, 32'h0, 32'h0, 1'b0, 1'b0, 32'h0};
endtask

`endif

//--- dv/ciClusterTb.sv
`timescale 1ns/1ps

module ciClusterTb
  import ciPkg::*, dataPkg::*;
();

  localparam int ClockPeriod = 40; // ns
  localparam int RandomCount = 8;

  logic        systemClock;
  logic        rstN;
  logic        ciStart;
  logic [7:0]  ciN;
  logic [31:0] ciDataA;
  logic [31:0] ciDataB;
  logic        stall;
  logic        busIdle;
  logic        ciDone;
  logic [31:0] ciResult;

  // reference model state for the profiler
  logic        modelEnabled;
  logic [31:0] modelCycles;
  logic [31:0] modelStall;
  logic [31:0] modelIdle;

  integer seed;

  `include "ciVectors.svh"

  localparam int WatchdogCycles =
    (NumVectors + 2 * RandomCount) * (MaxDelayMicro * SysClockPerMicro + 4) + 50;

  ciCluster UUT (
    .systemClock(systemClock),
    .rstN(rstN),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .stall(stall),
    .busIdle(busIdle),
    .ciDone(ciDone),
    .ciResult(ciResult)
  );

  initial begin
    systemClock = 1'b0;
    forever #(ClockPeriod / 2) systemClock = ~systemClock;
  end

  initial begin
    #(WatchdogCycles * ClockPeriod);
    $display("timeout: the simulation ran longer than %0d clock cycles", WatchdogCycles);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  // counters follow the driven levels as sampled before the edge
  always @(posedge systemClock) begin
    if (!rstN) begin
      modelEnabled = 1'b0;
      modelCycles  = '0;
      modelStall   = '0;
      modelIdle    = '0;
    end else begin
      if (ciStart && ciN == CiProfile && ciDataB[ProfClear]) begin
        modelCycles = '0;
        modelStall  = '0;
        modelIdle   = '0;
      end else if (modelEnabled) begin
        modelCycles = modelCycles + 1;
        if (stall) modelStall = modelStall + 1;
        if (busIdle) modelIdle = modelIdle + 1;
      end
      if (ciStart && ciN == CiProfile) begin
        if (ciDataB[ProfDisable]) modelEnabled = 1'b0;
        else if (ciDataB[ProfEnable]) modelEnabled = 1'b1;
      end
    end
  end

  function automatic logic [31:0] modelRead(input logic [1:0] sel);
    case (sel)
      SelCycles: return modelCycles;
      SelStall:  return modelStall;
      SelIdle:   return modelIdle;
      default:   return '0;
    endcase
  endfunction

  function automatic logic [31:0] expectedSwap(input logic [31:0] a, input logic [31:0] b);
    if (b[0]) return {a[23:16], a[31:24], a[7:0], a[15:8]}; // swap within half-words
    return {a[7:0], a[15:8], a[23:16], a[31:24]};
  endfunction

  function automatic logic [31:0] expectedGray(input logic [31:0] a);
    int r8;
    int g8;
    int b8;
    r8 = a[15:11] * 8;
    g8 = a[10:5] * 4;
    b8 = a[4:0] * 8;
    return (GrayRedWeight * r8 + GrayGreenWeight * g8 + GrayBlueWeight * b8) / 256;
  endfunction

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic runInstruction(input vecT v, input string label);
    int          waited;
    int          expectedWait;
    logic [31:0] expectedResult;
    expectedWait = (v.n == CiDelay) ? v.a * SysClockPerMicro : 0;
    @(posedge systemClock);
    ciStart <= 1'b1;
    ciN     <= v.n;
    ciDataA <= v.a;
    ciDataB <= v.b;
    stall   <= v.stall;
    busIdle <= v.idle;
    @(negedge systemClock);
    waited = 0;
    expectedResult = (v.n == CiProfile) ? modelRead(v.a[1:0]) : v.expected;
    while (ciDone !== 1'b1) begin
      if (waited > expectedWait + 8) begin
        $display("%s: ciDone did not arrive within %0d cycles", label, waited);
        $display("Test failed");
        $fatal(1, "instruction never completed");
      end
      @(posedge systemClock);
      ciStart <= 1'b0;
      ciDataA <= ~v.a; // operands only hold in the start cycle
      ciDataB <= ~v.b;
      @(negedge systemClock);
      waited++;
    end
    checkValue(ciResult, expectedResult, {label, " result"});
    checkValue(waited, expectedWait, {label, " cycles to done"});
    @(posedge systemClock);
    ciStart <= 1'b0; // idle cycle before the next start
  endtask

  initial begin
    vecT         v;
    logic [31:0] randA;
    logic [31:0] randB;
    rstN       = 1'b0;
    ciStart    = 1'b0;
    ciN        = '0;
    ciDataA    = '0;
    ciDataB    = '0;
    stall      = 1'b0;
    busIdle    = 1'b0;
    seed       = 32'hbff1850c;
    loadVectors();
    repeat (2) @(posedge systemClock);
    rstN <= 1'b1;

    repeat (4) begin
      @(negedge systemClock);
      checkValue(ciDone, 1'b0, "ciDone after reset");
      checkValue(ciResult, '0, "ciResult after reset");
    end

    for (int i = 0; i < NumVectors; i++) begin
      runInstruction(vectors[i], $sformatf("entry %0d", i));
    end

    for (int i = 0; i < RandomCount; i++) begin
      randA   = $random(seed);
      randB   = $random(seed);
      v.n     = CiSwapByte;
      v.a     = randA;
      v.b     = randB;
      v.stall = 1'b0;
      v.idle  = 1'b0;
      v.expected = expectedSwap(randA, randB);
      runInstruction(v, $sformatf("random swap %0d", i));
      v.n = CiGray;
      v.expected = expectedGray(randA);
      runInstruction(v, $sformatf("random gray %0d", i));
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+dv
common/ciPkg.sv
common/dataPkg.sv
logic/ciDecode.sv
execute/pixelOps.sv
execute/profileCounters.sv
execute/delayTimer.sv
logic/ciResult.sv
logic/ciCluster.sv
dv/ciClusterTb.sv
